//--- design/csr_pkg.sv
`default_nettype none

package csr_pkg;

   // Widths fixed by the RISC-V CSR format and the machine timer.
   localparam int CSR_XLEN = 32;
   localparam int MTIME_W  = 64;

   // One CSR data word as seen by the host.
   typedef logic [CSR_XLEN-1:0] csr_word_t;

   // The full machine timer and compare value.
   typedef logic [MTIME_W-1:0] mtime_t;

   // Selects one CSR through the low address bits of a host access.
   typedef logic [2:0] csr_sel_t;

   // Bit position inside one serial pass.
   typedef logic [4:0] csr_cnt_t;

   localparam csr_sel_t SEL_MSTATUS     = 3'd0;
   localparam csr_sel_t SEL_MIE         = 3'd1;
   localparam csr_sel_t SEL_MCAUSE      = 3'd2;
   localparam csr_sel_t SEL_MSCRATCH    = 3'd3;
   localparam csr_sel_t SEL_MTVEC       = 3'd4;
   localparam csr_sel_t SEL_MEPC        = 3'd5;
   localparam csr_sel_t SEL_MTIMECMP_LO = 3'd6;
   localparam csr_sel_t SEL_MTIMECMP_HI = 3'd7;

   // Source of the new CSR bit, in the same order as the serial core uses.
   typedef enum logic [1:0] {
      CSR_OP_READ  = 2'b00,
      CSR_OP_WRITE = 2'b01,
      CSR_OP_SET   = 2'b10,
      CSR_OP_CLR   = 2'b11
   } csr_op_e;

   // Reason for a trap request from the core.
   typedef enum logic [2:0] {
      TRAP_EBREAK         = 3'd0,
      TRAP_ECALL          = 3'd1,
      TRAP_LOAD_MISALIGN  = 3'd2,
      TRAP_STORE_MISALIGN = 3'd3,
      TRAP_JUMP_MISALIGN  = 3'd4,
      TRAP_TIMER_IRQ      = 3'd5
   } trap_kind_e;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_SHIFT,
      SEQ_ACK
   } seq_state_e;

endpackage

`default_nettype wire

//--- design/csr_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module csr_sequencer import csr_pkg::*; (
   input  wire             i_clk,
   input  wire             i_rst_n,
   // Wishbone classic slave.
   input  wire             i_wb_cyc,
   input  wire             i_wb_stb,
   input  wire             i_wb_we,
   input  wire [4:0]       i_wb_adr,
   input  wire csr_word_t  i_wb_dat,
   output csr_word_t       o_wb_dat,
   output logic            o_wb_ack,
   // Core requests.
   input  wire             i_trap_req,
   input  wire trap_kind_e i_trap_kind,
   input  wire csr_word_t  i_trap_pc,
   output logic            o_trap_ack,
   input  wire             i_mret_req,
   output logic            o_mret_ack,
   // Strobes and selects for the serial blocks.
   output logic            o_en,
   output logic            o_cnt0to3,
   output logic            o_cnt3,
   output logic            o_cnt7,
   output logic            o_cnt_done,
   output logic            o_trap_taken,
   output trap_kind_e      o_trap_kind,
   output logic            o_mret,
   output logic            o_mstatus_en,
   output logic            o_mie_en,
   output logic            o_mcause_en,
   output logic            o_store_en,
   output csr_sel_t        o_store_sel,
   output logic            o_timer_we,
   output logic            o_timer_hi,
   output csr_op_e         o_op,
   output logic            o_d,
   input  wire             i_q,
   input  wire csr_word_t  i_timer_rdata
);

   seq_state_e state;
   csr_cnt_t   cnt;
   logic       armed;
   logic       is_trap;
   logic       is_mret;
   csr_sel_t   sel;
   csr_op_e    op;
   trap_kind_e kind;
   csr_word_t  op_sr;
   csr_word_t  rd_sr;
   logic       shifting;
   logic       is_wb;
   logic       timer_sel;
   logic       store_sel;
   logic       wb_req;

   assign wb_req    = i_wb_cyc & i_wb_stb;
   assign is_wb     = !is_trap && !is_mret;
   assign timer_sel = (sel == SEL_MTIMECMP_LO) || (sel == SEL_MTIMECMP_HI);
   assign store_sel = (sel == SEL_MSCRATCH) || (sel == SEL_MTVEC) || (sel == SEL_MEPC);

   // The first SHIFT cycle only captures, so bits move once armed is set.
   assign shifting = (state == SEQ_SHIFT) && armed;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state   <= SEQ_IDLE;
         cnt     <= '0;
         armed   <= 1'b0;
         is_trap <= 1'b0;
         is_mret <= 1'b0;
         sel     <= SEL_MSTATUS;
         op      <= CSR_OP_READ;
         kind    <= TRAP_EBREAK;
      end else begin
         case (state)
            SEQ_IDLE: begin
               // Traps win over mret, and both win over the host.
               if (i_trap_req) begin
                  state   <= SEQ_SHIFT;
                  is_trap <= 1'b1;
                  is_mret <= 1'b0;
                  sel     <= SEL_MEPC;
                  op      <= CSR_OP_WRITE;
                  kind    <= i_trap_kind;
               end else if (i_mret_req) begin
                  state   <= SEQ_SHIFT;
                  is_trap <= 1'b0;
                  is_mret <= 1'b1;
                  sel     <= SEL_MSTATUS;
                  op      <= CSR_OP_READ;
               end else if (wb_req) begin
                  state   <= SEQ_SHIFT;
                  is_trap <= 1'b0;
                  is_mret <= 1'b0;
                  sel     <= i_wb_adr[2:0];
                  // A host read never changes the CSR.
                  op      <= i_wb_we ? csr_op_e'(i_wb_adr[4:3]) : CSR_OP_READ;
               end
            end
            SEQ_SHIFT: begin
               if (!armed) begin
                  armed <= 1'b1;
               end else begin
                  // The counter wraps back to zero on the last bit.
                  cnt <= cnt + 5'd1;
                  if (cnt == 5'd31) begin
                     state <= SEQ_ACK;
                     armed <= 1'b0;
                  end
               end
            end
            default: state <= SEQ_IDLE;
         endcase
      end
   end

   // Operand goes out LSB first, and read data comes in at the MSB.
   always_ff @(posedge i_clk) begin
      if (state == SEQ_IDLE) begin
         op_sr <= i_trap_req ? i_trap_pc : i_wb_dat;
      end else if (shifting) begin
         op_sr <= {1'b0, op_sr[CSR_XLEN-1:1]};
      end
      // The timer value is taken before the end-of-pass update changes it.
      if ((state == SEQ_SHIFT) && !armed) begin
         rd_sr <= i_timer_rdata;
      end else if (shifting && !timer_sel) begin
         rd_sr <= {i_q, rd_sr[CSR_XLEN-1:1]};
      end
   end

   assign o_wb_dat   = rd_sr;
   assign o_wb_ack   = (state == SEQ_ACK) && is_wb;
   assign o_trap_ack = (state == SEQ_ACK) && is_trap;
   assign o_mret_ack = (state == SEQ_ACK) && is_mret;

   assign o_en         = shifting;
   assign o_cnt0to3    = shifting && (cnt < 5'd4);
   assign o_cnt3       = shifting && (cnt == 5'd3);
   assign o_cnt7       = shifting && (cnt == 5'd7);
   assign o_cnt_done   = shifting && (cnt == 5'd31);
   assign o_trap_taken = o_cnt_done && is_trap;
   assign o_trap_kind  = kind;
   assign o_mret       = o_cnt_done && is_mret;

   // Machine bits are only touched by host passes.
   assign o_mstatus_en = shifting && is_wb && (sel == SEL_MSTATUS);
   assign o_mie_en     = shifting && is_wb && (sel == SEL_MIE);
   assign o_mcause_en  = shifting && is_wb && (sel == SEL_MCAUSE);
   assign o_store_en   = shifting && !is_mret && store_sel;
   assign o_store_sel  = sel;

   // The timer takes the held Wishbone data in parallel on the last bit.
   assign o_timer_we = o_cnt_done && is_wb && timer_sel;
   assign o_timer_hi = (sel == SEL_MTIMECMP_HI);
   assign o_op       = op;
   assign o_d        = op_sr[0];

   // Every ack is a single-cycle pulse, whichever requester it answers.
   a_ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_wb_ack || o_trap_ack || o_mret_ack) |=> !(o_wb_ack || o_trap_ack || o_mret_ack));

endmodule

`default_nettype wire

//--- design/csr_machine.sv
`timescale 1ns/10ps
`default_nettype none

module csr_machine import csr_pkg::*; (
   input  wire             i_clk,
   input  wire             i_rst_n,
   input  wire             i_en,
   input  wire             i_cnt0to3,
   input  wire             i_cnt3,
   input  wire             i_cnt7,
   input  wire             i_cnt_done,
   input  wire             i_trap_taken,
   input  wire trap_kind_e i_trap_kind,
   input  wire             i_mret,
   input  wire             i_mstatus_en,
   input  wire             i_mie_en,
   input  wire             i_mcause_en,
   input  wire csr_op_e    i_op,
   input  wire             i_d,
   input  wire             i_rf_csr_out,
   input  wire             i_mtip,
   output logic            o_csr_in,
   output logic            o_q,
   output logic            o_irq,
   output logic            o_new_irq
);

   logic       mstatus_mie;
   logic       mstatus_mpie;
   logic       mie_mtie;
   logic       mcause31;
   logic [3:0] mcause3_0;
   logic       mcause_bit;
   logic       csr_out;
   logic       csr_in;
   logic       timer_irq;
   logic       timer_irq_q;
   logic       new_irq_q;
   logic [3:0] trap_code;

   // Low mcause bits come out one per cycle, and bit 31 on the last count.
   assign mcause_bit = i_cnt0to3 ? mcause3_0[0] : (i_cnt_done ? mcause31 : 1'b0);

   // Only the selected source is nonzero, so a plain OR merges them.
   assign csr_out = (i_mstatus_en & i_cnt3 & mstatus_mie) |
                    (i_mie_en & i_cnt7 & mie_mtie) |
                    (i_mcause_en & i_en & mcause_bit) |
                    i_rf_csr_out;

   always_comb begin
      case (i_op)
         CSR_OP_WRITE: csr_in = i_d;
         CSR_OP_SET:   csr_in = csr_out | i_d;
         CSR_OP_CLR:   csr_in = csr_out & ~i_d;
         default:      csr_in = csr_out;
      endcase
   end

   // Exception codes follow the RISC-V mcause table.
   always_comb begin
      case (i_trap_kind)
         TRAP_EBREAK:         trap_code = 4'd3;
         TRAP_ECALL:          trap_code = 4'd11;
         TRAP_LOAD_MISALIGN:  trap_code = 4'd4;
         TRAP_STORE_MISALIGN: trap_code = 4'd6;
         TRAP_JUMP_MISALIGN:  trap_code = 4'd0;
         TRAP_TIMER_IRQ:      trap_code = 4'd7;
         default:             trap_code = 4'd0;
      endcase
   end

   assign o_csr_in = csr_in;
   assign o_q      = csr_out;

   // The timer interrupt fires only when both enables are set.
   assign timer_irq = i_mtip & mstatus_mie & mie_mtie;
   assign o_irq     = timer_irq;
   assign o_new_irq = new_irq_q;

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mstatus_mie  <= 1'b0;
         mstatus_mpie <= 1'b0;
         mie_mtie     <= 1'b0;
         mcause3_0    <= 4'd0;
         mcause31     <= 1'b0;
         timer_irq_q  <= 1'b0;
         new_irq_q    <= 1'b0;
      end else begin
         if (i_mie_en && i_cnt7) begin
            mie_mtie <= csr_in;
         end
         // A trap clears MIE, mret restores it, and a host pass writes bit 3.
         if (i_trap_taken) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= mstatus_mie;
         end else if (i_mret) begin
            mstatus_mie <= mstatus_mpie;
         end else if (i_mstatus_en && i_cnt3) begin
            mstatus_mie <= csr_in;
         end
         // The low code rotates so the next bit is always at position 0.
         if (i_trap_taken) begin
            mcause3_0 <= trap_code;
            mcause31  <= (i_trap_kind == TRAP_TIMER_IRQ);
         end else begin
            if (i_mcause_en && i_en && i_cnt0to3) begin
               mcause3_0 <= {csr_in, mcause3_0[3:1]};
            end
            if (i_mcause_en && i_cnt_done) begin
               mcause31 <= csr_in;
            end
         end
         timer_irq_q <= timer_irq;
         new_irq_q   <= timer_irq & ~timer_irq_q;
      end
   end

   // The sequencer never mixes a trap, an mret and a host pass on one cycle.
   a_excl_strobes: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(i_trap_taken && i_mret) &&
      !((i_trap_taken || i_mret) && (i_mstatus_en || i_mie_en || i_mcause_en)));

endmodule

`default_nettype wire

//--- design/csr_storage.sv
`timescale 1ns/10ps
`default_nettype none

module csr_storage import csr_pkg::*; (
   input  wire           i_clk,
   input  wire           i_rst_n,
   input  wire           i_en,
   input  wire csr_sel_t i_sel,
   input  wire           i_csr_in,
   output logic          o_rf_csr_out
);

   csr_word_t  regs [3];
   logic [1:0] idx;
   logic       hit;

   // Map the CSR selector onto one of the three shift registers.
   always_comb begin
      case (i_sel)
         SEL_MSCRATCH: begin
            idx = 2'd0;
            hit = 1'b1;
         end
         SEL_MTVEC: begin
            idx = 2'd1;
            hit = 1'b1;
         end
         SEL_MEPC: begin
            idx = 2'd2;
            hit = 1'b1;
         end
         default: begin
            idx = 2'd0;
            hit = 1'b0;
         end
      endcase
   end

   // Zero when idle, so the machine can OR this bit with its own.
   assign o_rf_csr_out = i_en & hit & regs[idx][0];

   // The selected register rotates right, with the new bit entering at the MSB.
   // After 32 cycles it holds the new word in its original alignment.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 3; i++) begin
            regs[i] <= '0;
         end
      end else if (i_en && hit) begin
         regs[idx] <= {i_csr_in, regs[idx][CSR_XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

//--- design/csr_mtimer.sv
`timescale 1ns/10ps
`default_nettype none

module csr_mtimer import csr_pkg::*; (
   input  wire            i_clk,
   input  wire            i_rst_n,
   input  wire            i_we,
   input  wire            i_hi,
   input  wire csr_op_e   i_op,
   input  wire csr_word_t i_wdata,
   output csr_word_t      o_rdata,
   output logic           o_mtip
);

   mtime_t    mtime;
   mtime_t    mtimecmp;
   csr_word_t cur;
   csr_word_t nxt;
   logic      mtip_q;

   // The selected half of the compare register.
   assign cur     = i_hi ? mtimecmp[MTIME_W-1:CSR_XLEN] : mtimecmp[CSR_XLEN-1:0];
   assign o_rdata = cur;
   assign o_mtip  = mtip_q;

   // Same read, write, set and clear rules as the serial CSRs.
   always_comb begin
      case (i_op)
         CSR_OP_WRITE: nxt = i_wdata;
         CSR_OP_SET:   nxt = cur | i_wdata;
         CSR_OP_CLR:   nxt = cur & ~i_wdata;
         default:      nxt = cur;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mtime    <= '0;
         // All ones keeps the interrupt quiet until software programs it.
         mtimecmp <= '1;
         mtip_q   <= 1'b0;
      end else begin
         mtime  <= mtime + 64'd1;
         mtip_q <= (mtime >= mtimecmp);
         if (i_we) begin
            if (i_hi) begin
               mtimecmp[MTIME_W-1:CSR_XLEN] <= nxt;
            end else begin
               mtimecmp[CSR_XLEN-1:0] <= nxt;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- design/csr_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module csr_subsystem import csr_pkg::*; (
   input  wire             i_clk,
   input  wire             i_rst_n,
   input  wire             i_wb_cyc,
   input  wire             i_wb_stb,
   input  wire             i_wb_we,
   input  wire [4:0]       i_wb_adr,
   input  wire csr_word_t  i_wb_dat,
   output wire csr_word_t  o_wb_dat,
   output wire             o_wb_ack,
   input  wire             i_trap_req,
   input  wire trap_kind_e i_trap_kind,
   input  wire csr_word_t  i_trap_pc,
   output wire             o_trap_ack,
   input  wire             i_mret_req,
   output wire             o_mret_ack,
   output wire             o_irq,
   output wire             o_new_irq
);

   logic       en;
   logic       cnt0to3;
   logic       cnt3;
   logic       cnt7;
   logic       cnt_done;
   logic       trap_taken;
   trap_kind_e trap_kind;
   logic       mret;
   logic       mstatus_en;
   logic       mie_en;
   logic       mcause_en;
   logic       store_en;
   csr_sel_t   store_sel;
   logic       timer_we;
   logic       timer_hi;
   csr_op_e    op;
   logic       d;
   logic       q;
   logic       csr_in;
   logic       rf_csr_out;
   logic       mtip;
   csr_word_t  timer_rdata;

   // The sequencer owns every pass and drives all strobes.
   csr_sequencer csr_sequencer_inst (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
      .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
      .i_trap_req(i_trap_req), .i_trap_kind(i_trap_kind), .i_trap_pc(i_trap_pc),
      .o_trap_ack(o_trap_ack), .i_mret_req(i_mret_req), .o_mret_ack(o_mret_ack),
      .o_en(en), .o_cnt0to3(cnt0to3), .o_cnt3(cnt3), .o_cnt7(cnt7), .o_cnt_done(cnt_done),
      .o_trap_taken(trap_taken), .o_trap_kind(trap_kind), .o_mret(mret),
      .o_mstatus_en(mstatus_en), .o_mie_en(mie_en), .o_mcause_en(mcause_en),
      .o_store_en(store_en), .o_store_sel(store_sel),
      .o_timer_we(timer_we), .o_timer_hi(timer_hi), .o_op(op),
      .o_d(d), .i_q(q), .i_timer_rdata(timer_rdata)
   );

   csr_machine csr_machine_inst (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_en(en),
      .i_cnt0to3(cnt0to3), .i_cnt3(cnt3), .i_cnt7(cnt7), .i_cnt_done(cnt_done),
      .i_trap_taken(trap_taken), .i_trap_kind(trap_kind), .i_mret(mret),
      .i_mstatus_en(mstatus_en), .i_mie_en(mie_en), .i_mcause_en(mcause_en),
      .i_op(op), .i_d(d), .i_rf_csr_out(rf_csr_out), .i_mtip(mtip),
      .o_csr_in(csr_in), .o_q(q), .o_irq(o_irq), .o_new_irq(o_new_irq)
   );

   csr_storage csr_storage_inst (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_en(store_en), .i_sel(store_sel),
      .i_csr_in(csr_in), .o_rf_csr_out(rf_csr_out)
   );

   // The host keeps its data stable until ack, so the timer takes it directly.
   csr_mtimer csr_mtimer_inst (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_we(timer_we), .i_hi(timer_hi),
      .i_op(op), .i_wdata(i_wb_dat), .o_rdata(timer_rdata), .o_mtip(mtip)
   );

endmodule

`default_nettype wire

//--- tests/tb_csr_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_csr_subsystem import csr_pkg::*; ();

   // Row kinds of the stimulus table.
   localparam logic [1:0] ROW_WB   = 2'd0;
   localparam logic [1:0] ROW_TRAP = 2'd1;
   localparam logic [1:0] ROW_MRET = 2'd2;
   localparam logic [1:0] ROW_IRQ  = 2'd3;

   // Cycles from the sampling edge to the ack, and the longest wait on o_irq.
   localparam int ACK_LATENCY = 34;
   localparam int IRQ_WAIT    = 64;

   // One table row; for irq rows dat[0] is the level and exp the pulse count.
   typedef struct packed {
      logic [1:0] kind;
      logic [4:0] adr;
      csr_word_t  dat;
      trap_kind_e tkind;
      csr_word_t  pc;
      csr_word_t  exp;
   } row_t;

   logic       i_clk;
   logic       i_rst_n;
   logic       i_wb_cyc;
   logic       i_wb_stb;
   logic       i_wb_we;
   logic [4:0] i_wb_adr;
   csr_word_t  i_wb_dat;
   csr_word_t  o_wb_dat;
   logic       o_wb_ack;
   logic       i_trap_req;
   trap_kind_e i_trap_kind;
   csr_word_t  i_trap_pc;
   logic       o_trap_ack;
   logic       i_mret_req;
   logic       o_mret_ack;
   logic       o_irq;
   logic       o_new_irq;

   row_t       rows[$];
   csr_word_t  model[8];
   logic       model_mpie;
   csr_word_t  lfsr_state  = 32'hdc15;
   int         irq_pulses  = 0;
   int         run_cycles  = 0;
   int         cycle_limit = 2000;

   csr_subsystem csr_subsystem_inst (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb), .i_wb_we(i_wb_we),
      .i_wb_adr(i_wb_adr), .i_wb_dat(i_wb_dat), .o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack),
      .i_trap_req(i_trap_req), .i_trap_kind(i_trap_kind), .i_trap_pc(i_trap_pc),
      .o_trap_ack(o_trap_ack), .i_mret_req(i_mret_req), .o_mret_ack(o_mret_ack),
      .o_irq(o_irq), .o_new_irq(o_new_irq)
   );

   initial begin
      i_clk = 1'b0;
      forever #4 i_clk = ~i_clk;
   end

   // Count new-interrupt pulses at the falling edge, where they are stable.
   always @(negedge i_clk) begin
      if (i_rst_n && o_new_irq) begin
         irq_pulses++;
      end
   end

   always @(posedge i_clk) begin
      run_cycles++;
      if (run_cycles > cycle_limit) begin
         $display("Timeout: the run went past its limit of %0d cycles.", cycle_limit);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "Stopping at the first failure.");
   endtask

   task automatic check_word(input csr_word_t got, input csr_word_t exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s is %08h, expected %08h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
         abort_run();
      end
   endtask

   // Right-shifting Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1.
   function automatic csr_word_t lfsr_next(input csr_word_t s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // One LFSR step for every bit of the word.
   function automatic csr_word_t rand_word();
      csr_word_t w;
      w = '0;
      for (int b = 0; b < CSR_XLEN; b++) begin
         w = {lfsr_state[0], w[CSR_XLEN-1:1]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return w;
   endfunction

   // Bits that each CSR implements; everything else reads as zero.
   function automatic csr_word_t field_mask(input csr_sel_t sel);
      case (sel)
         SEL_MSTATUS: return 32'h0000_0008;
         SEL_MIE:     return 32'h0000_0080;
         SEL_MCAUSE:  return 32'h8000_000f;
         default:     return 32'hffff_ffff;
      endcase
   endfunction

   // The mcause value that each trap kind must leave behind.
   function automatic csr_word_t cause_of(input trap_kind_e k);
      case (k)
         TRAP_EBREAK:         return 32'd3;
         TRAP_ECALL:          return 32'd11;
         TRAP_LOAD_MISALIGN:  return 32'd4;
         TRAP_STORE_MISALIGN: return 32'd6;
         TRAP_TIMER_IRQ:      return 32'h8000_0007;
         default:             return 32'd0;
      endcase
   endfunction

   // A host access; the expected read is the modeled value before the update.
   task automatic add_wb(input csr_op_e op, input csr_sel_t sel, input csr_word_t dat);
      row_t      r;
      csr_word_t nv;
      r = '0;
      r.kind  = ROW_WB;
      r.adr   = {op, sel};
      r.dat   = dat;
      r.tkind = TRAP_EBREAK;
      r.exp   = model[sel];
      case (op)
         CSR_OP_WRITE: nv = dat;
         CSR_OP_SET:   nv = model[sel] | dat;
         CSR_OP_CLR:   nv = model[sel] & ~dat;
         default:      nv = model[sel];
      endcase
      model[sel] = nv & field_mask(sel);
      rows.push_back(r);
   endtask

   // Trap entry saves MIE in MPIE, clears MIE, and records the pc and cause.
   task automatic add_trap(input trap_kind_e k, input csr_word_t pc);
      row_t r;
      r = '0;
      r.kind  = ROW_TRAP;
      r.tkind = k;
      r.pc    = pc;
      model[SEL_MEPC]    = pc;
      model_mpie         = model[SEL_MSTATUS][3];
      model[SEL_MSTATUS] = '0;
      model[SEL_MCAUSE]  = cause_of(k);
      rows.push_back(r);
   endtask

   task automatic add_mret();
      row_t r;
      r = '0;
      r.kind  = ROW_MRET;
      r.tkind = TRAP_EBREAK;
      model[SEL_MSTATUS] = model_mpie ? 32'h8 : 32'h0;
      rows.push_back(r);
   endtask

   task automatic add_irq(input logic level, input int pulses);
      row_t r;
      r = '0;
      r.kind  = ROW_IRQ;
      r.dat   = {31'd0, level};
      r.tkind = TRAP_EBREAK;
      r.exp   = pulses;
      rows.push_back(r);
   endtask

   task automatic build_table();
      trap_kind_e k;
      for (int i = 0; i < 8; i++) begin
         model[i] = '0;
      end
      model[SEL_MTIMECMP_LO] = '1;
      model[SEL_MTIMECMP_HI] = '1;
      model_mpie = 1'b0;
      // Storage registers take every bit, so random words show any slip.
      for (int s = 3; s <= 5; s++) begin
         add_wb(CSR_OP_WRITE, csr_sel_t'(s), rand_word());
         add_wb(CSR_OP_SET, csr_sel_t'(s), rand_word());
         add_wb(CSR_OP_CLR, csr_sel_t'(s), rand_word());
         add_wb(CSR_OP_READ, csr_sel_t'(s), '0);
      end
      // Machine CSRs keep only their implemented bits.
      for (int s = 0; s <= 2; s++) begin
         add_wb(CSR_OP_WRITE, csr_sel_t'(s), '1);
         add_wb(CSR_OP_READ, csr_sel_t'(s), '0);
         add_wb(CSR_OP_CLR, csr_sel_t'(s), rand_word());
         add_wb(CSR_OP_SET, csr_sel_t'(s), rand_word());
         add_wb(CSR_OP_READ, csr_sel_t'(s), '0);
         add_wb(CSR_OP_WRITE, csr_sel_t'(s), '0);
      end
      // Each trap kind is taken with MIE set, then undone by mret.
      k = k.first();
      repeat (6) begin
         add_wb(CSR_OP_SET, SEL_MSTATUS, rand_word() | 32'h8);
         add_trap(k, rand_word());
         add_wb(CSR_OP_READ, SEL_MEPC, '0);
         add_wb(CSR_OP_READ, SEL_MCAUSE, '0);
         add_wb(CSR_OP_READ, SEL_MSTATUS, '0);
         add_mret();
         add_wb(CSR_OP_READ, SEL_MSTATUS, '0);
         k = k.next();
      end
      // The compare value drops far below mtime, so mtip rises at once.
      add_wb(CSR_OP_CLR, SEL_MSTATUS, '1);
      add_irq(1'b0, 0);
      add_wb(CSR_OP_WRITE, SEL_MTIMECMP_HI, '0);
      add_wb(CSR_OP_READ, SEL_MTIMECMP_HI, '0);
      add_wb(CSR_OP_WRITE, SEL_MTIMECMP_LO, 32'h40);
      add_wb(CSR_OP_READ, SEL_MTIMECMP_LO, '0);
      add_wb(CSR_OP_SET, SEL_MIE, 32'h80);
      add_irq(1'b0, 0);
      add_wb(CSR_OP_SET, SEL_MSTATUS, 32'h8);
      add_irq(1'b1, 1);
      add_wb(CSR_OP_CLR, SEL_MIE, 32'h80);
      add_irq(1'b0, 1);
   endtask

   function automatic logic ack_of(input logic [1:0] kind);
      case (kind)
         ROW_WB:   return o_wb_ack;
         ROW_TRAP: return o_trap_ack;
         default:  return o_mret_ack;
      endcase
   endfunction

   task automatic run_row(input row_t r, input int idx);
      int   lat;
      int   waited;
      logic ack;
      if (r.kind == ROW_IRQ) begin
         waited = 0;
         while (o_irq !== r.dat[0] && waited < IRQ_WAIT) begin
            @(negedge i_clk);
            waited++;
         end
         check_bit(o_irq, r.dat[0], $sformatf("row %0d o_irq", idx));
         check_count(irq_pulses, int'(r.exp), $sformatf("row %0d o_new_irq pulses", idx));
      end else begin
         @(posedge i_clk);
         case (r.kind)
            ROW_WB: begin
               i_wb_cyc <= 1'b1;
               i_wb_stb <= 1'b1;
               i_wb_we  <= (r.adr[4:3] != 2'b00);
               i_wb_adr <= r.adr;
               i_wb_dat <= r.dat;
            end
            ROW_TRAP: begin
               i_trap_req  <= 1'b1;
               i_trap_kind <= r.tkind;
               i_trap_pc   <= r.pc;
            end
            default: i_mret_req <= 1'b1;
         endcase
         // The sequencer is idle here and samples the request on this edge.
         @(posedge i_clk);
         lat = 0;
         ack = 1'b0;
         while (!ack) begin
            @(negedge i_clk);
            lat++;
            ack = ack_of(r.kind);
         end
         check_count(lat, ACK_LATENCY, $sformatf("row %0d ack latency", idx));
         if (r.kind == ROW_WB) begin
            check_word(o_wb_dat, r.exp, $sformatf("row %0d read data", idx));
         end
         @(posedge i_clk);
         i_wb_cyc   <= 1'b0;
         i_wb_stb   <= 1'b0;
         i_wb_we    <= 1'b0;
         i_trap_req <= 1'b0;
         i_mret_req <= 1'b0;
         @(negedge i_clk);
         check_bit(ack_of(r.kind), 1'b0, $sformatf("row %0d ack one cycle later", idx));
      end
   endtask

   initial begin
      i_rst_n     = 1'b0;
      i_wb_cyc    = 1'b0;
      i_wb_stb    = 1'b0;
      i_wb_we     = 1'b0;
      i_wb_adr    = '0;
      i_wb_dat    = '0;
      i_trap_req  = 1'b0;
      i_trap_kind = TRAP_EBREAK;
      i_trap_pc   = '0;
      i_mret_req  = 1'b0;
      build_table();
      cycle_limit = rows.size() * 40 + 2000;
      repeat (16) @(posedge i_clk);
      i_rst_n <= 1'b1;
      @(posedge i_clk);
      @(negedge i_clk);
      // All outputs must be quiet straight out of reset.
      check_bit(o_wb_ack, 1'b0, "o_wb_ack after reset");
      check_bit(o_trap_ack, 1'b0, "o_trap_ack after reset");
      check_bit(o_mret_ack, 1'b0, "o_mret_ack after reset");
      check_bit(o_irq, 1'b0, "o_irq after reset");
      check_bit(o_new_irq, 1'b0, "o_new_irq after reset");
      for (int i = 0; i < rows.size(); i++) begin
         run_row(rows[i], i);
      end
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
design/csr_pkg.sv
design/csr_sequencer.sv
design/csr_machine.sv
design/csr_storage.sv
design/csr_mtimer.sv
design/csr_subsystem.sv
tests/tb_csr_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_csr_subsystem
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation did not pass, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
